//--- source/fprint_pkg.sv
package fprint_pkg;

	// Bus address bits 7..4 hold the physical core id and bits 3..0 the register offset.
	localparam int ADDR_W      = 8;
	localparam int DATA_W      = 32;
	localparam int HALF_W      = 16;
	localparam int CRC_W       = 32;
	localparam int KEY_W       = 4;
	localparam int NUM_TASKS   = 16;
	localparam int NUM_CORES   = 3;
	localparam int RING_ADDR_W = 4;
	localparam int RING_DEPTH  = 2 ** RING_ADDR_W;
	localparam int FIFO_DEPTH  = 4;
	localparam int FIFO_PTR_W  = $clog2(FIFO_DEPTH);

	localparam logic [3:0] CS_OFFSET  = 4'h4;
	localparam logic [3:0] CRC_OFFSET = 4'h8;

	typedef logic [1:0] logical_core_t;

	// A table entry of this value means the physical core takes no part in the task.
	localparam logical_core_t CORE_NONE = 2'd3;

	// State codes of the bus capture FSM.
	localparam int CAP_STATE_W = 2;
	localparam logic [CAP_STATE_W-1:0] CAP_IDLE    = 2'd0;
	localparam logic [CAP_STATE_W-1:0] CAP_PUSH    = 2'd1;
	localparam logic [CAP_STATE_W-1:0] CAP_RELEASE = 2'd2;

	// State codes of the command executor.
	localparam int CTL_STATE_W = 3;
	localparam logic [CTL_STATE_W-1:0] CTL_IDLE    = 3'd0;
	localparam logic [CTL_STATE_W-1:0] CTL_CAT_ACK = 3'd1;
	localparam logic [CTL_STATE_W-1:0] CTL_POP     = 3'd2;
	localparam logic [CTL_STATE_W-1:0] CTL_DECODE  = 3'd3;
	localparam logic [CTL_STATE_W-1:0] CTL_EXEC    = 3'd4;

	// State codes of the vote and result handshake.
	localparam int VOTE_STATE_W = 2;
	localparam logic [VOTE_STATE_W-1:0] VOTE_IDLE  = 2'd0;
	localparam logic [VOTE_STATE_W-1:0] VOTE_REQ   = 2'd1;
	localparam logic [VOTE_STATE_W-1:0] VOTE_ACK   = 2'd2;
	localparam logic [VOTE_STATE_W-1:0] VOTE_CLEAR = 2'd3;

	typedef struct packed {
		logic [15:0]      unused_hi;
		logic [1:0]       pad;
		logic [KEY_W-1:0] phys;
		logic [3:0]       offset;
		logic             unused_lo;
		logic             checkout;
		logic [KEY_W-1:0] task_id;
	} fprint_cs_t;

	typedef struct packed {
		logic [HALF_W-1:0] half;
		logic [1:0]        pad;
		logic [KEY_W-1:0]  phys;
		logic [3:0]        offset;
		logic              upper;
		logic              unused_lo;
		logic [KEY_W-1:0]  task_id;
	} fprint_crc_t;

	// The offset field sits at the same place in both views and selects the one that applies.
	typedef union packed {
		fprint_cs_t  cs;
		fprint_crc_t crc;
	} fprint_entry_u;

endpackage

//--- source/fprint_store_if.sv
`timescale 1ns/100ps

interface fprint_store_if;
	import fprint_pkg::*;

	logic                 store_write;
	logical_core_t        store_core;
	logic                 store_upper;
	logic [HALF_W-1:0]    store_half;
	logic [KEY_W-1:0]     store_task;
	logic [NUM_TASKS-1:0] checkin_done;
	logic                 clear;
	logic [KEY_W-1:0]     clear_task;

	// The executor fills the rings and reports checkins; the vote stage asks for clears.
	modport store (
		output store_write, store_core, store_upper, store_half, store_task, checkin_done,
		input  clear, clear_task
	);

	modport vote (
		input  store_write, store_core, store_upper, store_half, store_task, checkin_done,
		output clear, clear_task
	);

endinterface

//--- source/fprint_fifo.sv
`timescale 1ns/100ps

module fprint_fifo (
	input  logic                      clk,
	input  logic                      reset,
	input  fprint_pkg::fprint_entry_u data_in,
	input  logic                      wr_en,
	input  logic                      rd_en,
	output fprint_pkg::fprint_entry_u data_out,
	output logic                      empty,
	output logic                      full
);
	import fprint_pkg::*;

	fprint_entry_u         mem [FIFO_DEPTH];
	logic [FIFO_PTR_W-1:0] wr_ptr;
	logic [FIFO_PTR_W-1:0] rd_ptr;
	logic [FIFO_PTR_W:0]   count;
	logic                  wr_ok;
	logic                  rd_ok;

	assign wr_ok    = wr_en && !full;
	assign rd_ok    = rd_en && !empty;
	assign empty    = (count == '0);
	assign full     = (count == (FIFO_PTR_W + 1)'(FIFO_DEPTH));
	assign data_out = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (wr_ok) begin
			mem[wr_ptr] <= data_in;
		end
	end

	// The depth is a power of two, so the pointers wrap on their own.
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (wr_ok) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (rd_ok) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({wr_ok, rd_ok})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

//--- source/fprint_capture.sv
`timescale 1ns/100ps

module fprint_capture (
	input  logic                            clk,
	input  logic                            reset,
	input  logic [fprint_pkg::ADDR_W-1:0]   address,
	input  logic                            write,
	input  logic [fprint_pkg::DATA_W-1:0]   writedata,
	input  logic                            entry_pop,
	output logic                            waitrequest,
	output logic                            entry_valid,
	output fprint_pkg::fprint_entry_u       entry
);
	import fprint_pkg::*;

	logic [CAP_STATE_W-1:0] state;
	fprint_entry_u          packed_word;
	logic                   push;
	logic                   fifo_empty;
	logic                   fifo_full;

	// Upper data half, pad, full address, then the flag and task bits of the data.
	assign packed_word = {writedata[DATA_W-1:HALF_W], 2'b00, address, writedata[5:0]};

	// The host holds write until it sees waitrequest low, so one push per handshake.
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= CAP_IDLE;
		end else begin
			case (state)
				CAP_IDLE: begin
					if (write && !fifo_full) begin
						state <= CAP_PUSH;
					end
				end
				CAP_PUSH:    state <= CAP_RELEASE;
				CAP_RELEASE: state <= CAP_IDLE;
				default:     state <= CAP_IDLE;
			endcase
		end
	end

	assign push        = (state == CAP_PUSH);
	assign waitrequest = (state != CAP_RELEASE);
	assign entry_valid = !fifo_empty;

	fprint_fifo fifo0 (
		.clk      (clk),
		.reset    (reset),
		.data_in  (packed_word),
		.wr_en    (push),
		.rd_en    (entry_pop),
		.data_out (entry),
		.empty    (fifo_empty),
		.full     (fifo_full)
	);

endmodule

//--- source/fprint_control.sv
`timescale 1ns/100ps

module fprint_control (
	input  logic                          clk,
	input  logic                          reset,
	input  logic                          entry_valid,
	input  fprint_pkg::fprint_entry_u     entry,
	output logic                          entry_pop,
	input  logic                          cat_req,
	input  logic [fprint_pkg::KEY_W-1:0]  cat_task,
	input  logic [fprint_pkg::KEY_W-1:0]  cat_phys,
	input  fprint_pkg::logical_core_t     cat_core,
	output logic                          cat_ack,
	fprint_store_if.store                 store
);
	import fprint_pkg::*;

	logic [CTL_STATE_W-1:0] state;
	logical_core_t          cat_table [NUM_TASKS][NUM_TASKS];
	logic [NUM_TASKS-1:0]   checkout_bits [NUM_CORES];
	logic [NUM_TASKS-1:0]   checkin_bits [NUM_CORES];
	fprint_entry_u          entry_q;
	logical_core_t          core_q;
	logical_core_t          lookup_core;
	logic                   clear_pend;
	logic [KEY_W-1:0]       clear_task_q;
	logic                   is_cs;
	logic                   is_crc;
	logic                   cat_write;
	logic                   serve_clear;
	logic                   core_checked_out;
	logic [NUM_TASKS-1:0]   done_all;
	logic [NUM_TASKS-1:0]   clear_mask;

	assign is_cs       = (entry_q.cs.offset == CS_OFFSET);
	assign is_crc      = (entry_q.crc.offset == CRC_OFFSET);
	assign lookup_core = cat_table[entry_q.cs.task_id][entry_q.cs.phys];
	assign cat_write   = (state == CTL_IDLE) && cat_req;
	assign serve_clear = (state == CTL_IDLE) && !cat_req && clear_pend;

	// Table writes come first, then a waiting clear, then the queue.
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= CTL_IDLE;
		end else begin
			case (state)
				CTL_IDLE: begin
					if (cat_req) begin
						state <= CTL_CAT_ACK;
					end else if (!clear_pend && entry_valid) begin
						state <= CTL_POP;
					end
				end
				CTL_CAT_ACK: begin
					if (!cat_req) begin
						state <= CTL_IDLE;
					end
				end
				CTL_POP: state <= CTL_DECODE;
				CTL_DECODE: begin
					// Unknown offsets and unmapped cores end here.
					if ((is_cs || is_crc) && lookup_core != CORE_NONE) begin
						state <= CTL_EXEC;
					end else begin
						state <= CTL_IDLE;
					end
				end
				default: state <= CTL_IDLE;
			endcase
		end
	end

	assign entry_pop = (state == CTL_POP);
	assign cat_ack   = (state == CTL_CAT_ACK);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int t = 0; t < NUM_TASKS; t++) begin
				for (int p = 0; p < NUM_TASKS; p++) begin
					cat_table[t][p] <= CORE_NONE;
				end
			end
		end else if (cat_write) begin
			cat_table[cat_task][cat_phys] <= cat_core;
		end
	end

	// The vote stage pulses clear once; it waits here until the executor is idle.
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			clear_pend <= 1'b0;
		end else if (store.clear) begin
			clear_pend <= 1'b1;
		end else if (serve_clear) begin
			clear_pend <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (store.clear) begin
			clear_task_q <= store.clear_task;
		end
		if (state == CTL_POP) begin
			entry_q <= entry;
		end
		if (state == CTL_DECODE) begin
			core_q <= lookup_core;
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int c = 0; c < NUM_CORES; c++) begin
				checkout_bits[c] <= '0;
				checkin_bits[c]  <= '0;
			end
		end else begin
			for (int c = 0; c < NUM_CORES; c++) begin
				if (serve_clear) begin
					checkout_bits[c][clear_task_q] <= 1'b0;
					checkin_bits[c][clear_task_q]  <= 1'b0;
				end else if (state == CTL_EXEC && is_cs && core_q == logical_core_t'(c)) begin
					if (entry_q.cs.checkout) begin
						checkout_bits[c][entry_q.cs.task_id] <= 1'b1;
					end else if (checkout_bits[c][entry_q.cs.task_id]) begin
						checkin_bits[c][entry_q.cs.task_id] <= 1'b1;
					end
				end
			end
		end
	end

	always_comb begin
		core_checked_out = 1'b0;
		done_all         = '1;
		for (int c = 0; c < NUM_CORES; c++) begin
			if (core_q == logical_core_t'(c)) begin
				core_checked_out = checkout_bits[c][entry_q.crc.task_id];
			end
			done_all &= checkin_bits[c];
		end
	end

	// A task waiting for its clear must not be voted on a second time.
	assign clear_mask = clear_pend ? (NUM_TASKS'(1) << clear_task_q) : '0;

	assign store.checkin_done = done_all & ~clear_mask;
	assign store.store_write  = (state == CTL_EXEC) && is_crc && core_checked_out;
	assign store.store_core   = core_q;
	assign store.store_upper  = entry_q.crc.upper;
	assign store.store_half   = entry_q.crc.half;
	assign store.store_task   = entry_q.crc.task_id;

endmodule

//--- source/fprint_vote.sv
`timescale 1ns/100ps

module fprint_vote (
	input  logic                         clk,
	input  logic                         reset,
	output logic                         result_req,
	output logic [fprint_pkg::KEY_W-1:0] result_task,
	output logic                         result_match,
	input  logic                         result_ack,
	fprint_store_if.vote                 store
);
	import fprint_pkg::*;

	logic [CRC_W-1:0]        ring_crc [NUM_CORES][RING_DEPTH];
	logic [KEY_W-1:0]        ring_task [NUM_CORES][RING_DEPTH];
	logic [HALF_W-1:0]       stage_lo [NUM_CORES];
	logic [RING_ADDR_W-1:0]  head [NUM_CORES];
	logic [RING_ADDR_W-1:0]  tail [NUM_CORES];
	logic [CRC_W-1:0]        crc_out [NUM_CORES];
	logic [KEY_W-1:0]        task_out [NUM_CORES];
	logic [NUM_CORES-1:0]    upper_write;
	logic [VOTE_STATE_W-1:0] state;
	logic                    all_ready;
	logic                    vote_now;
	logic                    fp_equal;
	logic                    task_equal;

	always_comb begin
		all_ready = 1'b1;
		for (int c = 0; c < NUM_CORES; c++) begin
			upper_write[c] = store.store_write && store.store_upper &&
				store.store_core == logical_core_t'(c);
			crc_out[c]  = ring_crc[c][tail[c]];
			task_out[c] = ring_task[c][tail[c]];
			all_ready   = all_ready && (head[c] != tail[c]);
		end
	end

	assign fp_equal   = (crc_out[0] == crc_out[1]) && (crc_out[1] == crc_out[2]);
	assign task_equal = (task_out[0] == task_out[1]) && (task_out[1] == task_out[2]);
	assign vote_now   = (state == VOTE_IDLE) && all_ready && store.checkin_done[task_out[0]];

	// A lower half waits in staging; the upper half completes the ring entry.
	always_ff @(posedge clk) begin
		for (int c = 0; c < NUM_CORES; c++) begin
			if (upper_write[c]) begin
				ring_crc[c][head[c]]  <= {store.store_half, stage_lo[c]};
				ring_task[c][head[c]] <= store.store_task;
			end else if (store.store_write && store.store_core == logical_core_t'(c)) begin
				stage_lo[c] <= store.store_half;
			end
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int c = 0; c < NUM_CORES; c++) begin
				head[c] <= '0;
				tail[c] <= '0;
			end
		end else begin
			for (int c = 0; c < NUM_CORES; c++) begin
				if (upper_write[c]) begin
					head[c] <= head[c] + 1'b1;
				end
				if (state == VOTE_CLEAR) begin
					tail[c] <= tail[c] + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= VOTE_IDLE;
		end else begin
			case (state)
				VOTE_IDLE: begin
					if (vote_now) begin
						state <= VOTE_REQ;
					end
				end
				VOTE_REQ: begin
					if (result_ack) begin
						state <= VOTE_ACK;
					end
				end
				VOTE_ACK: begin
					if (!result_ack) begin
						state <= VOTE_CLEAR;
					end
				end
				default: state <= VOTE_IDLE;
			endcase
		end
	end

	// The result fields are taken when the vote starts and stay put for the handshake.
	always_ff @(posedge clk) begin
		if (vote_now) begin
			result_task  <= task_out[0];
			result_match <= fp_equal && task_equal;
		end
	end

	assign result_req       = (state == VOTE_REQ);
	assign store.clear      = (state == VOTE_CLEAR);
	assign store.clear_task = result_task;

endmodule

//--- source/fprint_unit.sv
`timescale 1ns/100ps

module fprint_unit (
	input  logic                          clk,
	input  logic                          reset,
	input  logic [fprint_pkg::ADDR_W-1:0] address,
	input  logic                          write,
	input  logic [fprint_pkg::DATA_W-1:0] writedata,
	output logic                          waitrequest,
	input  logic                          cat_req,
	input  logic [fprint_pkg::KEY_W-1:0]  cat_task,
	input  logic [fprint_pkg::KEY_W-1:0]  cat_phys,
	input  fprint_pkg::logical_core_t     cat_core,
	output logic                          cat_ack,
	output logic                          result_req,
	output logic [fprint_pkg::KEY_W-1:0]  result_task,
	output logic                          result_match,
	input  logic                          result_ack
);
	import fprint_pkg::*;

	fprint_entry_u entry;
	logic          entry_valid;
	logic          entry_pop;

	fprint_store_if store_bus ();

	fprint_capture capture0 (
		.clk         (clk),
		.reset       (reset),
		.address     (address),
		.write       (write),
		.writedata   (writedata),
		.entry_pop   (entry_pop),
		.waitrequest (waitrequest),
		.entry_valid (entry_valid),
		.entry       (entry)
	);

	fprint_control control0 (
		.clk         (clk),
		.reset       (reset),
		.entry_valid (entry_valid),
		.entry       (entry),
		.entry_pop   (entry_pop),
		.cat_req     (cat_req),
		.cat_task    (cat_task),
		.cat_phys    (cat_phys),
		.cat_core    (cat_core),
		.cat_ack     (cat_ack),
		.store       (store_bus.store)
	);

	fprint_vote vote0 (
		.clk          (clk),
		.reset        (reset),
		.result_req   (result_req),
		.result_task  (result_task),
		.result_match (result_match),
		.result_ack   (result_ack),
		.store        (store_bus.vote)
	);

endmodule

//--- verification/fprint_unit_tb.sv
`timescale 1ns/100ps

module fprint_unit_tb;
	import fprint_pkg::*;

	localparam int CLK_PERIOD     = 20;
	localparam int RESET_CYCLES   = 5;
	localparam int HANDSHAKE_WAIT = 200;
	localparam int QUIET_CYCLES   = 100;
	localparam int BURST_HOLD     = 40;
	// Bus writes and table handshakes issued by the test sequence.
	localparam int PLANNED_WRITES = 63;
	localparam int PLANNED_CATS   = 9;
	localparam int WATCHDOG_CYCLES = RESET_CYCLES + PLANNED_WRITES * 20 +
		PLANNED_CATS * (BURST_HOLD + 10) + 5 * HANDSHAKE_WAIT + QUIET_CYCLES;

	logic                 clk;
	logic                 reset;
	logic [ADDR_W-1:0]    address;
	logic                 write;
	logic [DATA_W-1:0]    writedata;
	logic                 waitrequest;
	logic                 cat_req;
	logic [KEY_W-1:0]     cat_task;
	logic [KEY_W-1:0]     cat_phys;
	logical_core_t        cat_core;
	logic                 cat_ack;
	logic                 result_req;
	logic [KEY_W-1:0]     result_task;
	logic                 result_match;
	logic                 result_ack;

	integer               seed;
	int                   mismatch_count = 0;
	int                   error_count = 0;
	int                   result_mismatches = 0;
	int                   result_errors = 0;
	int                   write_count = 0;
	int                   release_count = 0;
	int                   longest_wait = 0;
	// Each entry is {task, match} in the order the votes are due.
	logic [KEY_W:0]       expected_q [$];

	fprint_unit dut0 (
		.clk          (clk),
		.reset        (reset),
		.address      (address),
		.write        (write),
		.writedata    (writedata),
		.waitrequest  (waitrequest),
		.cat_req      (cat_req),
		.cat_task     (cat_task),
		.cat_phys     (cat_phys),
		.cat_core     (cat_core),
		.cat_ack      (cat_ack),
		.result_req   (result_req),
		.result_task  (result_task),
		.result_match (result_match),
		.result_ack   (result_ack)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// A vote matches only when all three logical cores sent the same fingerprint.
	function automatic logic expected_match(input logic [31:0] fp0, fp1, fp2);
		return (fp0 == fp1) && (fp1 == fp2);
	endfunction

	function automatic void print_counts();
		$display("Closing counts: %0d mismatches, %0d other errors",
			mismatch_count + result_mismatches, error_count + result_errors);
	endfunction

	task automatic bus_write(input logic [3:0] phys, input logic [3:0] offset,
		input logic [31:0] data);
		int waited;
		waited = 0;
		address   <= {phys, offset};
		writedata <= data;
		write     <= 1'b1;
		do begin
			@(posedge clk);
			waited++;
		end while (waitrequest && waited < HANDSHAKE_WAIT);
		write <= 1'b0;
		write_count++;
		if (waitrequest) begin
			error_count++;
			$display("Bus write to core %0d offset %0h was never accepted", phys, offset);
		end
		if (waited > longest_wait) begin
			longest_wait = waited;
		end
	endtask

	task automatic send_cs(input logic [3:0] phys, input logic [3:0] task_id, input logic out);
		bus_write(phys, CS_OFFSET, {26'd0, 1'b0, out, task_id});
	endtask

	// Lower half first, since the upper half completes the ring entry.
	task automatic send_fp(input logic [3:0] phys, input logic [3:0] task_id,
		input logic [31:0] fp);
		bus_write(phys, CRC_OFFSET, {fp[15:0], 10'd0, 1'b0, 1'b0, task_id});
		bus_write(phys, CRC_OFFSET, {fp[31:16], 10'd0, 1'b1, 1'b0, task_id});
	endtask

	task automatic run_core(input logic [3:0] phys, input logic [3:0] task_id,
		input logic [31:0] fp);
		send_cs(phys, task_id, 1'b1);
		send_fp(phys, task_id, fp);
		send_cs(phys, task_id, 1'b0);
	endtask

	task automatic map_core(input logic [3:0] task_id, input logic [3:0] phys,
		input logical_core_t core, input int hold);
		int waited;
		if (cat_ack) begin
			error_count++;
			$display("cat_ack was already high before the request for task %0d", task_id);
		end
		cat_task <= task_id;
		cat_phys <= phys;
		cat_core <= core;
		cat_req  <= 1'b1;
		waited = 0;
		do begin
			@(posedge clk);
			waited++;
		end while (!cat_ack && waited < HANDSHAKE_WAIT);
		if (!cat_ack) begin
			error_count++;
			$display("cat_ack never rose for task %0d core %0d", task_id, phys);
		end
		repeat (hold) begin
			@(posedge clk);
			if (!cat_ack) begin
				error_count++;
				$display("cat_ack fell while cat_req was still high");
			end
		end
		cat_req <= 1'b0;
		waited = 0;
		do begin
			@(posedge clk);
			waited++;
		end while (cat_ack && waited < HANDSHAKE_WAIT);
		if (cat_ack) begin
			error_count++;
			$display("cat_ack stayed high after cat_req fell");
		end
	endtask

	task automatic expect_result(input logic [3:0] task_id, input logic match);
		expected_q.push_back({task_id, match});
	endtask

	// The clear reaches the executor a few cycles after the acknowledge.
	task automatic wait_results();
		int waited;
		waited = 0;
		while (expected_q.size() != 0 && waited < HANDSHAKE_WAIT) begin
			@(posedge clk);
			waited++;
		end
		repeat (4) @(posedge clk);
	endtask

	always @(posedge clk) begin
		if (!reset && !waitrequest) begin
			release_count <= release_count + 1;
		end
	end

	initial begin : compare_results
		logic [KEY_W-1:0] got_task;
		logic             got_match;
		logic [KEY_W:0]   want;
		int               waited;
		result_ack = 1'b0;
		@(negedge reset);
		forever begin
			@(posedge clk);
			if (result_req) begin
				got_task   = result_task;
				got_match  = result_match;
				result_ack <= 1'b1;
				waited = 0;
				do begin
					@(posedge clk);
					waited++;
				end while (result_req && waited < HANDSHAKE_WAIT);
				if (result_req) begin
					result_errors++;
					$display("result_req stayed high after result_ack rose");
				end
				result_ack <= 1'b0;
				if (expected_q.size() == 0) begin
					result_errors++;
					$display("Unexpected extra result for task %0d at %0t", got_task, $time);
				end else begin
					want = expected_q.pop_front();
					if (got_task !== want[KEY_W:1]) begin
						result_mismatches++;
						$display("MISMATCH at %0t: result_task %0d, expected %0d",
							$time, got_task, want[KEY_W:1]);
					end
					if (got_match !== want[0]) begin
						result_mismatches++;
						$display("MISMATCH at %0t: result_match %0b for task %0d, expected %0b",
							$time, got_match, got_task, want[0]);
					end
				end
			end
		end
	end

	initial begin : watchdog
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Watchdog expired after %0d cycles with the sequence unfinished",
			WATCHDOG_CYCLES);
		print_counts();
		$display("Test FAILED");
		$finish;
	end

	initial begin : run_tests
		logic [31:0] fp_a;
		logic [31:0] fp_b;
		logic [31:0] fp_c;
		logic [31:0] stray;
		seed      = 72;
		reset     = 1'b1;
		address   = '0;
		write     = 1'b0;
		writedata = '0;
		cat_req   = 1'b0;
		cat_task  = '0;
		cat_phys  = '0;
		cat_core  = CORE_NONE;
		repeat (RESET_CYCLES) @(posedge clk);
		reset <= 1'b0;
		@(posedge clk);

		// Task 3 has three agreeing cores, and physical core 7 stays unmapped.
		map_core(4'd3, 4'd1, 2'd0, 0);
		map_core(4'd3, 4'd2, 2'd1, 0);
		map_core(4'd3, 4'd3, 2'd2, 0);
		fp_a = $random(seed);
		expect_result(4'd3, expected_match(fp_a, fp_a, fp_a));
		run_core(4'd7, 4'd3, ~fp_a);
		run_core(4'd1, 4'd3, fp_a);
		run_core(4'd2, 4'd3, fp_a);
		run_core(4'd3, 4'd3, fp_a);
		wait_results();

		// Task 5 disagrees in one core. A long table handshake stalls the executor,
		// so the burst of writes behind it fills the queue.
		map_core(4'd5, 4'd4, 2'd2, 0);
		map_core(4'd5, 4'd5, 2'd0, 0);
		fp_a = $random(seed);
		fp_b = fp_a;
		fp_c = fp_a ^ 32'h0001_0000;
		expect_result(4'd5, expected_match(fp_a, fp_b, fp_c));
		longest_wait = 0;
		fork
			map_core(4'd5, 4'd6, 2'd1, BURST_HOLD);
			begin
				run_core(4'd4, 4'd5, fp_a);
				run_core(4'd5, 4'd5, fp_b);
			end
		join
		run_core(4'd6, 4'd5, fp_c);
		wait_results();
		if (longest_wait < BURST_HOLD / 2) begin
			error_count++;
			$display("No write was held back, so the queue never filled during the burst");
		end

		// Core 12 reports task 9 before its checkout; that fingerprint must vanish.
		map_core(4'd9, 4'd10, 2'd0, 0);
		map_core(4'd9, 4'd11, 2'd1, 0);
		map_core(4'd9, 4'd12, 2'd2, 0);
		fp_a  = $random(seed);
		stray = $random(seed);
		expect_result(4'd9, expected_match(fp_a, fp_a, fp_a));
		send_fp(4'd12, 4'd9, stray);
		run_core(4'd10, 4'd9, fp_a);
		run_core(4'd11, 4'd9, fp_a);
		run_core(4'd12, 4'd9, fp_a);
		wait_results();

		// Task 9 was cleared, so reports without a new checkout give nothing.
		send_fp(4'd10, 4'd9, fp_a);
		send_cs(4'd10, 4'd9, 1'b0);
		send_fp(4'd11, 4'd9, ~fp_a);
		send_cs(4'd11, 4'd9, 1'b0);
		send_fp(4'd12, 4'd9, fp_a ^ 32'h1);
		send_cs(4'd12, 4'd9, 1'b0);
		repeat (QUIET_CYCLES) @(posedge clk);

		// A fresh checkout brings task 9 back, with the rings still aligned.
		fp_a = $random(seed);
		expect_result(4'd9, expected_match(fp_a, fp_a, fp_a));
		run_core(4'd10, 4'd9, fp_a);
		run_core(4'd11, 4'd9, fp_a);
		run_core(4'd12, 4'd9, fp_a);
		wait_results();

		if (expected_q.size() != 0) begin
			error_count++;
			$display("%0d expected results never arrived", expected_q.size());
		end
		if (release_count != write_count) begin
			mismatch_count++;
			$display("MISMATCH at %0t: %0d waitrequest releases for %0d bus writes",
				$time, release_count, write_count);
		end
		print_counts();
		if (mismatch_count + result_mismatches + error_count + result_errors == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

//--- vlog.f
source/fprint_pkg.sv
source/fprint_store_if.sv
source/fprint_fifo.sv
source/fprint_capture.sv
source/fprint_control.sv
source/fprint_vote.sv
source/fprint_unit.sv
verification/fprint_unit_tb.sv

//--- Makefile
VERILATOR  = verilator
FLAGS      = --binary --timing
LINT_FLAGS = --lint-only --timing
TOP        = fprint_unit_tb
FILELIST   = vlog.f
BUILD_DIR  = obj_dir
LOG        = sim.log
PASS_MSG   = Test OK

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
